//--- sources.f
source/rs_pkg.sv
source/rs_select.sv
source/rs_dispatch.sv
source/rs_entry_array.sv
source/rs_top.sv
testbench/rs_tb.sv

//--- run.sh
#!/usr/bin/env bash
# builds the reservation station and its testbench with Verilator, then runs it
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing -j 0 \
    -f sources.f \
    --top-module rs_tb \
    -o rs_sim

./obj_dir/rs_sim 2>&1 | tee "$LOG"

if grep -q "ERRORS FOUND" "$LOG"; then
    echo "simulation failed, see $LOG"
    exit 1
fi

echo "simulation passed"
exit 0

//--- testbench/rs_tb.sv
`timescale 1ns/1ps

module rs_tb
    import rs_pkg::*;
();

    localparam int DEPTH = 8;
    localparam int DISPATCH_WIDTH = 2;
    localparam int NUM_ALU = 2;
    localparam int NUM_MULT = 1;
    localparam int TIMEOUT = 40;

    logic                                         clock;
    logic                                         reset;
    logic [DISPATCH_WIDTH-1:0]                    dispatch_valid;
    logic [DISPATCH_WIDTH-1:0][FU_TYPE_WIDTH-1:0] dispatch_fu_type;
    logic [DISPATCH_WIDTH-1:0][INST_WIDTH-1:0]    dispatch_inst;
    logic [DISPATCH_WIDTH-1:0][TAG_WIDTH-1:0]     dispatch_dest;
    logic [DISPATCH_WIDTH-1:0][TAG_WIDTH-1:0]     dispatch_src1;
    logic [DISPATCH_WIDTH-1:0]                    dispatch_src1_ready;
    logic [DISPATCH_WIDTH-1:0][TAG_WIDTH-1:0]     dispatch_src2;
    logic [DISPATCH_WIDTH-1:0]                    dispatch_src2_ready;
    logic [BR_MASK_WIDTH-1:0]                     b_id;
    logic [CDB_WIDTH-1:0]                         cdb_valid;
    logic [CDB_WIDTH-1:0][TAG_WIDTH-1:0]          cdb_tag;
    logic [BR_TASK_WIDTH-1:0]                     br_task;
    logic [BR_MASK_WIDTH-1:0]                     rem_b_id;
    logic [NUM_ALU-1:0]                           alu_busy;
    logic [NUM_ALU-1:0]                           alu_issue_valid;
    logic [NUM_ALU-1:0][INST_WIDTH-1:0]           alu_issue_inst;
    logic [NUM_ALU-1:0][TAG_WIDTH-1:0]            alu_issue_dest;
    logic [NUM_MULT-1:0]                          mult_busy;
    logic [NUM_MULT-1:0]                          mult_issue_valid;
    logic [NUM_MULT-1:0][INST_WIDTH-1:0]          mult_issue_inst;
    logic [NUM_MULT-1:0][TAG_WIDTH-1:0]           mult_issue_dest;
    logic [$clog2(DISPATCH_WIDTH+1)-1:0]          open_entries;

    // expected station contents
    logic [DEPTH-1:0]                    model_valid;
    logic [DEPTH-1:0][INST_WIDTH-1:0]    model_inst;
    logic [DEPTH-1:0][TAG_WIDTH-1:0]     model_dest;
    logic [DEPTH-1:0][BR_MASK_WIDTH-1:0] model_mask;
    logic [BR_MASK_WIDTH-1:0]            model_running;

    integer seed;
    int     error_count;
    int     timeout_count;
    string  test_name;

    rs_top #(
        .DEPTH(DEPTH),
        .DISPATCH_WIDTH(DISPATCH_WIDTH),
        .NUM_ALU(NUM_ALU),
        .NUM_MULT(NUM_MULT)
    ) rs_top_inst (.*);

    always #5 clock = ~clock;

    ////////////////////////////////////////////////////////////
    // model
    ////////////////////////////////////////////////////////////

    function automatic int lowest_free();
        for (int i = 0; i < DEPTH; i++) begin
            if (!model_valid[i]) begin
                return i;
            end
        end
        return -1;
    endfunction

    // lowest valid slot is the next one a free unit should get
    function automatic int oldest_slot();
        for (int i = 0; i < DEPTH; i++) begin
            if (model_valid[i]) begin
                return i;
            end
        end
        return -1;
    endfunction

    function automatic int expected_open();
        int free_slots;
        free_slots = 0;
        for (int i = 0; i < DEPTH; i++) begin
            if (!model_valid[i]) begin
                free_slots++;
            end
        end
        if (free_slots > DISPATCH_WIDTH) begin
            return DISPATCH_WIDTH;
        end
        return free_slots;
    endfunction

    // running mask plus the new branch, minus the resolved one
    function automatic logic [BR_MASK_WIDTH-1:0] lane_mask();
        return (model_running | b_id) & ~rem_b_id;
    endfunction

    function automatic void apply_branch();
        for (int i = 0; i < DEPTH; i++) begin
            if (br_task == BR_SQUASH && (model_mask[i] & rem_b_id) != '0) begin
                model_valid[i] = 1'b0;
            end
            if (br_task == BR_CLEAR) begin
                model_mask[i] = model_mask[i] & ~rem_b_id;
            end
        end
        model_running = lane_mask();
    endfunction

    ////////////////////////////////////////////////////////////
    // drive and check helpers
    ////////////////////////////////////////////////////////////

    task automatic report_mismatch(input string what, input logic [31:0] expected,
                                   input logic [31:0] actual);
        error_count++;
        $display("** Error: %s %s expected %h actual %h", test_name, what, expected, actual);
    endtask

    task automatic idle_inputs();
        dispatch_valid = '0;
        dispatch_fu_type = '0;
        dispatch_inst = '0;
        dispatch_dest = '0;
        dispatch_src1 = '0;
        dispatch_src1_ready = '0;
        dispatch_src2 = '0;
        dispatch_src2_ready = '0;
        b_id = '0;
        cdb_valid = '0;
        cdb_tag = '0;
        br_task = BR_NONE;
        rem_b_id = '0;
    endtask

    // open_entries only moves at the rising edge, so it is settled here
    task automatic next_cycle();
        @(negedge clock);
        if (int'(open_entries) != expected_open()) begin
            report_mismatch("open_entries", 32'(expected_open()), 32'(open_entries));
        end
        idle_inputs();
    endtask

    task automatic load_lane(input int k, input logic [FU_TYPE_WIDTH-1:0] fu,
                             input logic src2_ready, input logic [TAG_WIDTH-1:0] src2,
                             output int slot);
        slot = lowest_free();
        dispatch_valid[k] = 1'b1;
        dispatch_fu_type[k] = fu;
        dispatch_inst[k] = $random(seed);
        dispatch_dest[k] = TAG_WIDTH'($random(seed));
        dispatch_src1[k] = TAG_WIDTH'($random(seed));
        dispatch_src1_ready[k] = 1'b1;
        dispatch_src2[k] = src2;
        dispatch_src2_ready[k] = src2_ready;
        model_valid[slot] = 1'b1;
        model_inst[slot] = dispatch_inst[k];
        model_dest[slot] = dispatch_dest[k];
        model_mask[slot] = lane_mask();
    endtask

    task automatic expect_no_issue();
        if ({alu_issue_valid, mult_issue_valid} !== 3'b000) begin
            report_mismatch("issue valids", 32'h0, 32'({alu_issue_valid, mult_issue_valid}));
        end
    endtask

    task automatic expect_mult_oldest();
        int slot;
        slot = oldest_slot();
        if (mult_issue_valid !== 1'b1) begin
            report_mismatch("mult_issue_valid", 32'h1, 32'(mult_issue_valid));
        end else if (slot < 0) begin
            error_count++;
            $display("%s: multiplier issued with no entry waiting", test_name);
        end else begin
            if (mult_issue_inst[0] !== model_inst[slot]) begin
                report_mismatch("mult_issue_inst", model_inst[slot], mult_issue_inst[0]);
            end
            if (mult_issue_dest[0] !== model_dest[slot]) begin
                report_mismatch("mult_issue_dest", 32'(model_dest[slot]),
                                32'(mult_issue_dest[0]));
            end
            model_valid[slot] = 1'b0;
        end
    endtask

    task automatic wait_mult_issue(output int cycles);
        cycles = 0;
        do begin
            next_cycle();
            #1;
            cycles++;
        end while (mult_issue_valid !== 1'b1 && cycles < TIMEOUT);
        if (mult_issue_valid !== 1'b1) begin
            timeout_count++;
            $display("%s: no multiplier issue within %0d cycles", test_name, TIMEOUT);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////

    task automatic test_reset_state();
        test_name = "test_reset_state";
        next_cycle();
        #1;
        expect_no_issue();
        if (open_entries !== 2'(DISPATCH_WIDTH)) begin
            report_mismatch("open_entries", 32'(DISPATCH_WIDTH), 32'(open_entries));
        end
    endtask

    task automatic test_ready_dispatch_issue();
        int s0;
        int s1;
        test_name = "test_ready_dispatch_issue";
        next_cycle();
        load_lane(0, FU_ALU, 1'b1, TAG_WIDTH'($random(seed)), s0);
        load_lane(1, FU_ALU, 1'b1, TAG_WIDTH'($random(seed)), s1);
        #1;
        expect_no_issue();
        next_cycle();
        #1;
        if (alu_issue_valid !== 2'b11) begin
            report_mismatch("alu_issue_valid", 32'h3, 32'(alu_issue_valid));
        end
        if (alu_issue_inst[0] !== model_inst[s0]) begin
            report_mismatch("alu_issue_inst[0]", model_inst[s0], alu_issue_inst[0]);
        end
        if (alu_issue_dest[0] !== model_dest[s0]) begin
            report_mismatch("alu_issue_dest[0]", 32'(model_dest[s0]), 32'(alu_issue_dest[0]));
        end
        if (alu_issue_inst[1] !== model_inst[s1]) begin
            report_mismatch("alu_issue_inst[1]", model_inst[s1], alu_issue_inst[1]);
        end
        if (alu_issue_dest[1] !== model_dest[s1]) begin
            report_mismatch("alu_issue_dest[1]", 32'(model_dest[s1]), 32'(alu_issue_dest[1]));
        end
        model_valid[s0] = 1'b0;
        model_valid[s1] = 1'b0;
        next_cycle();
    endtask

    task automatic test_wakeup();
        int slot;
        logic [TAG_WIDTH-1:0] tag;
        test_name = "test_wakeup";
        tag = TAG_WIDTH'($random(seed));
        next_cycle();
        load_lane(0, FU_MULT, 1'b0, tag, slot);
        repeat (4) begin
            next_cycle();
            #1;
            expect_no_issue();
        end
        // issue comes in the broadcast cycle itself
        next_cycle();
        cdb_valid = 2'b10;
        cdb_tag[1] = tag;
        #1;
        expect_mult_oldest();
        next_cycle();
    endtask

    task automatic test_backpressure_order();
        int slot;
        int cycles;
        test_name = "test_backpressure_order";
        mult_busy = 1'b1;
        next_cycle();
        load_lane(0, FU_MULT, 1'b1, TAG_WIDTH'($random(seed)), slot);
        load_lane(1, FU_MULT, 1'b1, TAG_WIDTH'($random(seed)), slot);
        next_cycle();
        load_lane(0, FU_MULT, 1'b1, TAG_WIDTH'($random(seed)), slot);
        #1;
        expect_no_issue();
        repeat (2) begin
            next_cycle();
            #1;
            expect_no_issue();
        end
        next_cycle();
        mult_busy = 1'b0;
        #1;
        expect_mult_oldest();
        repeat (2) begin
            wait_mult_issue(cycles);
            if (cycles != 1) begin
                report_mismatch("cycles between issues", 32'h1, 32'(cycles));
            end
            expect_mult_oldest();
        end
        next_cycle();
        #1;
        expect_no_issue();
    endtask

    task automatic test_squash();
        int slot;
        int cycles;
        test_name = "test_squash";
        mult_busy = 1'b1;
        next_cycle();
        load_lane(0, FU_MULT, 1'b1, TAG_WIDTH'($random(seed)), slot);
        load_lane(1, FU_MULT, 1'b1, TAG_WIDTH'($random(seed)), slot);
        // everything from here on sits behind branch bit 1
        next_cycle();
        b_id = 4'b0010;
        apply_branch();
        load_lane(0, FU_MULT, 1'b1, TAG_WIDTH'($random(seed)), slot);
        load_lane(1, FU_MULT, 1'b1, TAG_WIDTH'($random(seed)), slot);
        next_cycle();
        load_lane(0, FU_MULT, 1'b1, TAG_WIDTH'($random(seed)), slot);
        load_lane(1, FU_MULT, 1'b1, TAG_WIDTH'($random(seed)), slot);
        next_cycle();
        load_lane(0, FU_MULT, 1'b1, TAG_WIDTH'($random(seed)), slot);
        next_cycle();
        br_task = BR_SQUASH;
        rem_b_id = 4'b0010;
        apply_branch();
        #1;
        expect_no_issue();
        next_cycle();
        mult_busy = 1'b0;
        #1;
        expect_mult_oldest();
        wait_mult_issue(cycles);
        if (cycles != 1) begin
            report_mismatch("cycles between issues", 32'h1, 32'(cycles));
        end
        expect_mult_oldest();
        repeat (4) begin
            next_cycle();
            #1;
            expect_no_issue();
        end
    endtask

    task automatic test_clear();
        int slot;
        logic [TAG_WIDTH-1:0] tag;
        test_name = "test_clear";
        tag = TAG_WIDTH'($random(seed));
        next_cycle();
        b_id = 4'b0100;
        apply_branch();
        load_lane(0, FU_MULT, 1'b0, tag, slot);
        next_cycle();
        br_task = BR_CLEAR;
        rem_b_id = 4'b0100;
        apply_branch();
        #1;
        expect_no_issue();
        // bit already gone from the mask, so this squash misses
        next_cycle();
        br_task = BR_SQUASH;
        rem_b_id = 4'b0100;
        apply_branch();
        #1;
        expect_no_issue();
        next_cycle();
        cdb_valid = 2'b01;
        cdb_tag[0] = tag;
        #1;
        expect_mult_oldest();
        next_cycle();
    endtask

    initial begin
        seed = 32'h772b_543b;
        error_count = 0;
        timeout_count = 0;
        model_valid = '0;
        model_inst = '0;
        model_dest = '0;
        model_mask = '0;
        model_running = '0;
        clock = 1'b0;
        reset = 1'b1;
        alu_busy = '0;
        mult_busy = '0;
        idle_inputs();
        repeat (10) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        test_reset_state();
        test_ready_dispatch_issue();
        test_wakeup();
        test_backpressure_order();
        test_squash();
        test_clear();

        $display("errors: %0d, timeouts: %0d", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- source/rs_top.sv
`timescale 1ns/1ps

module rs_top
    import rs_pkg::*;
#(
    parameter int DEPTH = 8,
    parameter int DISPATCH_WIDTH = 2,
    parameter int NUM_ALU = 2,
    parameter int NUM_MULT = 1
) (
    input  logic                                         clock,
    input  logic                                         reset,

    // dispatch lanes
    input  logic [DISPATCH_WIDTH-1:0]                    dispatch_valid,
    input  logic [DISPATCH_WIDTH-1:0][FU_TYPE_WIDTH-1:0] dispatch_fu_type,
    input  logic [DISPATCH_WIDTH-1:0][INST_WIDTH-1:0]    dispatch_inst,
    input  logic [DISPATCH_WIDTH-1:0][TAG_WIDTH-1:0]     dispatch_dest,
    input  logic [DISPATCH_WIDTH-1:0][TAG_WIDTH-1:0]     dispatch_src1,
    input  logic [DISPATCH_WIDTH-1:0]                    dispatch_src1_ready,
    input  logic [DISPATCH_WIDTH-1:0][TAG_WIDTH-1:0]     dispatch_src2,
    input  logic [DISPATCH_WIDTH-1:0]                    dispatch_src2_ready,
    input  logic [BR_MASK_WIDTH-1:0]                     b_id,

    // common data bus
    input  logic [CDB_WIDTH-1:0]                         cdb_valid,
    input  logic [CDB_WIDTH-1:0][TAG_WIDTH-1:0]          cdb_tag,

    // branch resolution
    input  logic [BR_TASK_WIDTH-1:0]                     br_task,
    input  logic [BR_MASK_WIDTH-1:0]                     rem_b_id,

    // alu issue
    input  logic [NUM_ALU-1:0]                           alu_busy,
    output logic [NUM_ALU-1:0]                           alu_issue_valid,
    output logic [NUM_ALU-1:0][INST_WIDTH-1:0]           alu_issue_inst,
    output logic [NUM_ALU-1:0][TAG_WIDTH-1:0]            alu_issue_dest,

    // multiplier issue
    input  logic [NUM_MULT-1:0]                          mult_busy,
    output logic [NUM_MULT-1:0]                          mult_issue_valid,
    output logic [NUM_MULT-1:0][INST_WIDTH-1:0]          mult_issue_inst,
    output logic [NUM_MULT-1:0][TAG_WIDTH-1:0]           mult_issue_dest,

    output logic [$clog2(DISPATCH_WIDTH+1)-1:0]          open_entries
);

    localparam int OPEN_WIDTH = $clog2(DISPATCH_WIDTH + 1);
    localparam int COUNT_WIDTH = $clog2(DEPTH + 1);

    logic [DEPTH-1:0]                    slot_valid;
    logic [DISPATCH_WIDTH-1:0][DEPTH-1:0] lane_slot_onehot;
    logic [BR_MASK_WIDTH-1:0]            dispatch_mask;
    logic [DEPTH-1:0]                    alu_req;
    logic [DEPTH-1:0]                    mult_req;
    logic [NUM_ALU-1:0][DEPTH-1:0]       alu_grant;
    logic [NUM_MULT-1:0][DEPTH-1:0]      mult_grant;
    logic [COUNT_WIDTH-1:0]              free_count;

    ////////////////////////////////////////////////////////////
    // blocks
    ////////////////////////////////////////////////////////////

    rs_dispatch #(
        .DEPTH(DEPTH),
        .DISPATCH_WIDTH(DISPATCH_WIDTH)
    ) slot_dispatch (
        .clock(clock),
        .reset(reset),
        .dispatch_valid(dispatch_valid),
        .slot_valid(slot_valid),
        .b_id(b_id),
        .br_task(br_task),
        .rem_b_id(rem_b_id),
        .lane_slot_onehot(lane_slot_onehot),
        .dispatch_mask(dispatch_mask)
    );

    rs_entry_array #(
        .DEPTH(DEPTH),
        .DISPATCH_WIDTH(DISPATCH_WIDTH),
        .NUM_ALU(NUM_ALU),
        .NUM_MULT(NUM_MULT)
    ) entry_array (
        .clock(clock),
        .reset(reset),
        .dispatch_fu_type(dispatch_fu_type),
        .dispatch_inst(dispatch_inst),
        .dispatch_dest(dispatch_dest),
        .dispatch_src1(dispatch_src1),
        .dispatch_src1_ready(dispatch_src1_ready),
        .dispatch_src2(dispatch_src2),
        .dispatch_src2_ready(dispatch_src2_ready),
        .lane_slot_onehot(lane_slot_onehot),
        .dispatch_mask(dispatch_mask),
        .cdb_valid(cdb_valid),
        .cdb_tag(cdb_tag),
        .br_task(br_task),
        .rem_b_id(rem_b_id),
        .alu_grant(alu_grant),
        .mult_grant(mult_grant),
        .slot_valid(slot_valid),
        .alu_req(alu_req),
        .mult_req(mult_req),
        .alu_issue_valid(alu_issue_valid),
        .alu_issue_inst(alu_issue_inst),
        .alu_issue_dest(alu_issue_dest),
        .mult_issue_valid(mult_issue_valid),
        .mult_issue_inst(mult_issue_inst),
        .mult_issue_dest(mult_issue_dest)
    );

    rs_select #(
        .DEPTH(DEPTH),
        .NUM_FU(NUM_ALU)
    ) alu_select (
        .req(alu_req),
        .busy(alu_busy),
        .grant_onehot(alu_grant)
    );

    rs_select #(
        .DEPTH(DEPTH),
        .NUM_FU(NUM_MULT)
    ) mult_select (
        .req(mult_req),
        .busy(mult_busy),
        .grant_onehot(mult_grant)
    );

    ////////////////////////////////////////////////////////////
    // open entries
    ////////////////////////////////////////////////////////////

    // counted from registered slot state, capped at the lane count
    always_comb begin
        free_count = '0;
        for (int i = 0; i < DEPTH; i++) begin
            free_count = free_count + COUNT_WIDTH'(!slot_valid[i]);
        end

        if (free_count > COUNT_WIDTH'(DISPATCH_WIDTH)) begin
            open_entries = OPEN_WIDTH'(DISPATCH_WIDTH);
        end else begin
            open_entries = OPEN_WIDTH'(free_count);
        end
    end

endmodule

//--- source/rs_entry_array.sv
`timescale 1ns/1ps

module rs_entry_array
    import rs_pkg::*;
#(
    parameter int DEPTH = 8,
    parameter int DISPATCH_WIDTH = 2,
    parameter int NUM_ALU = 2,
    parameter int NUM_MULT = 1
) (
    input  logic                                         clock,
    input  logic                                         reset,

    // renamed lanes
    input  logic [DISPATCH_WIDTH-1:0][FU_TYPE_WIDTH-1:0] dispatch_fu_type,
    input  logic [DISPATCH_WIDTH-1:0][INST_WIDTH-1:0]    dispatch_inst,
    input  logic [DISPATCH_WIDTH-1:0][TAG_WIDTH-1:0]     dispatch_dest,
    input  logic [DISPATCH_WIDTH-1:0][TAG_WIDTH-1:0]     dispatch_src1,
    input  logic [DISPATCH_WIDTH-1:0]                    dispatch_src1_ready,
    input  logic [DISPATCH_WIDTH-1:0][TAG_WIDTH-1:0]     dispatch_src2,
    input  logic [DISPATCH_WIDTH-1:0]                    dispatch_src2_ready,
    input  logic [DISPATCH_WIDTH-1:0][DEPTH-1:0]         lane_slot_onehot,
    input  logic [BR_MASK_WIDTH-1:0]                     dispatch_mask,

    input  logic [CDB_WIDTH-1:0]                         cdb_valid,
    input  logic [CDB_WIDTH-1:0][TAG_WIDTH-1:0]          cdb_tag,

    input  logic [BR_TASK_WIDTH-1:0]                     br_task,
    input  logic [BR_MASK_WIDTH-1:0]                     rem_b_id,

    input  logic [NUM_ALU-1:0][DEPTH-1:0]                alu_grant,
    input  logic [NUM_MULT-1:0][DEPTH-1:0]               mult_grant,

    output logic [DEPTH-1:0]                             slot_valid,
    output logic [DEPTH-1:0]                             alu_req,
    output logic [DEPTH-1:0]                             mult_req,

    output logic [NUM_ALU-1:0]                           alu_issue_valid,
    output logic [NUM_ALU-1:0][INST_WIDTH-1:0]           alu_issue_inst,
    output logic [NUM_ALU-1:0][TAG_WIDTH-1:0]            alu_issue_dest,
    output logic [NUM_MULT-1:0]                          mult_issue_valid,
    output logic [NUM_MULT-1:0][INST_WIDTH-1:0]          mult_issue_inst,
    output logic [NUM_MULT-1:0][TAG_WIDTH-1:0]           mult_issue_dest
);

    // entry storage
    logic [DEPTH-1:0][FU_TYPE_WIDTH-1:0] slot_fu;
    logic [DEPTH-1:0][INST_WIDTH-1:0]    slot_inst;
    logic [DEPTH-1:0][TAG_WIDTH-1:0]     slot_dest;
    logic [DEPTH-1:0][TAG_WIDTH-1:0]     slot_src1;
    logic [DEPTH-1:0][TAG_WIDTH-1:0]     slot_src2;
    logic [DEPTH-1:0]                    slot_src1_ready;
    logic [DEPTH-1:0]                    slot_src2_ready;
    logic [DEPTH-1:0][BR_MASK_WIDTH-1:0] slot_mask;

    // after squash, clear and wakeup
    logic [DEPTH-1:0]                    squash_hit;
    logic [DEPTH-1:0]                    live;
    logic [DEPTH-1:0]                    woken1;
    logic [DEPTH-1:0]                    woken2;
    logic [DEPTH-1:0][BR_MASK_WIDTH-1:0] cleared_mask;
    logic [DEPTH-1:0]                    issued;

    // next state
    logic [DEPTH-1:0]                    next_valid;
    logic [DEPTH-1:0][FU_TYPE_WIDTH-1:0] next_fu;
    logic [DEPTH-1:0][INST_WIDTH-1:0]    next_inst;
    logic [DEPTH-1:0][TAG_WIDTH-1:0]     next_dest;
    logic [DEPTH-1:0][TAG_WIDTH-1:0]     next_src1;
    logic [DEPTH-1:0][TAG_WIDTH-1:0]     next_src2;
    logic [DEPTH-1:0]                    next_src1_ready;
    logic [DEPTH-1:0]                    next_src2_ready;
    logic [DEPTH-1:0][BR_MASK_WIDTH-1:0] next_mask;

    // true when any valid broadcast carries this tag
    function automatic logic tag_on_bus(
        input logic [TAG_WIDTH-1:0]                tag,
        input logic [CDB_WIDTH-1:0]                valid,
        input logic [CDB_WIDTH-1:0][TAG_WIDTH-1:0] tags
    );
        logic hit;
        hit = 1'b0;
        for (int b = 0; b < CDB_WIDTH; b++) begin
            if (valid[b] && tags[b] == tag) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    ////////////////////////////////////////////////////////////
    // squash, clear, wakeup and requests
    ////////////////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            squash_hit[i] = (br_task == BR_SQUASH) && ((slot_mask[i] & rem_b_id) != '0);
            live[i] = slot_valid[i] && !squash_hit[i];

            cleared_mask[i] = slot_mask[i];
            if (br_task == BR_CLEAR) begin
                cleared_mask[i] = slot_mask[i] & ~rem_b_id;
            end

            // same-cycle wakeup
            woken1[i] = slot_src1_ready[i] || tag_on_bus(slot_src1[i], cdb_valid, cdb_tag);
            woken2[i] = slot_src2_ready[i] || tag_on_bus(slot_src2[i], cdb_valid, cdb_tag);

            alu_req[i] = live[i] && woken1[i] && woken2[i] && (slot_fu[i] == FU_ALU);
            mult_req[i] = live[i] && woken1[i] && woken2[i] && (slot_fu[i] == FU_MULT);
        end
    end

    ////////////////////////////////////////////////////////////
    // issue mux
    ////////////////////////////////////////////////////////////

    always_comb begin
        issued = '0;

        for (int u = 0; u < NUM_ALU; u++) begin
            alu_issue_valid[u] = |alu_grant[u];
            alu_issue_inst[u] = '0;
            alu_issue_dest[u] = '0;
            for (int j = 0; j < DEPTH; j++) begin
                if (alu_grant[u][j]) begin
                    alu_issue_inst[u] = slot_inst[j];
                    alu_issue_dest[u] = slot_dest[j];
                    issued[j] = 1'b1;
                end
            end
        end

        for (int u = 0; u < NUM_MULT; u++) begin
            mult_issue_valid[u] = |mult_grant[u];
            mult_issue_inst[u] = '0;
            mult_issue_dest[u] = '0;
            for (int j = 0; j < DEPTH; j++) begin
                if (mult_grant[u][j]) begin
                    mult_issue_inst[u] = slot_inst[j];
                    mult_issue_dest[u] = slot_dest[j];
                    issued[j] = 1'b1;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // next state and dispatch writes
    ////////////////////////////////////////////////////////////

    always_comb begin
        next_valid = live & ~issued;
        next_fu = slot_fu;
        next_inst = slot_inst;
        next_dest = slot_dest;
        next_src1 = slot_src1;
        next_src2 = slot_src2;
        next_src1_ready = woken1;
        next_src2_ready = woken2;
        next_mask = cleared_mask;

        for (int k = 0; k < DISPATCH_WIDTH; k++) begin
            for (int j = 0; j < DEPTH; j++) begin
                if (lane_slot_onehot[k][j]) begin
                    next_valid[j] = 1'b1;
                    next_fu[j] = dispatch_fu_type[k];
                    next_inst[j] = dispatch_inst[k];
                    next_dest[j] = dispatch_dest[k];
                    next_src1[j] = dispatch_src1[k];
                    next_src2[j] = dispatch_src2[k];
                    // a tag broadcast while dispatching must not be missed
                    next_src1_ready[j] = dispatch_src1_ready[k] ||
                        tag_on_bus(dispatch_src1[k], cdb_valid, cdb_tag);
                    next_src2_ready[j] = dispatch_src2_ready[k] ||
                        tag_on_bus(dispatch_src2[k], cdb_valid, cdb_tag);
                    next_mask[j] = dispatch_mask;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            slot_valid <= '0;
        end else begin
            slot_valid <= next_valid;
        end
    end

    // entry payload, ready bits and masks
    always_ff @(posedge clock) begin
        slot_fu <= next_fu;
        slot_inst <= next_inst;
        slot_dest <= next_dest;
        slot_src1 <= next_src1;
        slot_src2 <= next_src2;
        slot_src1_ready <= next_src1_ready;
        slot_src2_ready <= next_src2_ready;
        slot_mask <= next_mask;
    end

endmodule

//--- source/rs_dispatch.sv
`timescale 1ns/1ps

module rs_dispatch
    import rs_pkg::*;
#(
    parameter int DEPTH = 8,
    parameter int DISPATCH_WIDTH = 2
) (
    input  logic                                clock,
    input  logic                                reset,

    input  logic [DISPATCH_WIDTH-1:0]           dispatch_valid,
    input  logic [DEPTH-1:0]                    slot_valid,

    input  logic [BR_MASK_WIDTH-1:0]            b_id,
    input  logic [BR_TASK_WIDTH-1:0]            br_task,
    input  logic [BR_MASK_WIDTH-1:0]            rem_b_id,

    output logic [DISPATCH_WIDTH-1:0][DEPTH-1:0] lane_slot_onehot,
    output logic [BR_MASK_WIDTH-1:0]            dispatch_mask
);

    // branches still unresolved at this point in program order
    logic [BR_MASK_WIDTH-1:0] running_mask;
    logic [BR_MASK_WIDTH-1:0] resolved_bits;

    ////////////////////////////////////////////////////////////
    // slot picking
    ////////////////////////////////////////////////////////////

    // free slots come from registered state only, so a slot freed
    // by issue or squash this cycle is handed out one cycle later
    // and the picker always agrees with open_entries
    rs_select #(
        .DEPTH(DEPTH),
        .NUM_FU(DISPATCH_WIDTH)
    ) slot_picker (
        .req(~slot_valid),
        .busy(~dispatch_valid),
        .grant_onehot(lane_slot_onehot)
    );

    ////////////////////////////////////////////////////////////
    // branch mask
    ////////////////////////////////////////////////////////////

    // a resolved branch frees its bit whether it squashed or cleared
    assign resolved_bits = (br_task == BR_NONE) ? '0 : rem_b_id;

    // new branch bit joins before this cycle's lanes are written
    assign dispatch_mask = (running_mask | b_id) & ~resolved_bits;

    always_ff @(posedge clock) begin
        if (reset) begin
            running_mask <= '0;
        end else begin
            running_mask <= dispatch_mask;
        end
    end

endmodule

//--- source/rs_select.sv
`timescale 1ns/1ps

module rs_select #(
    parameter int DEPTH = 8,
    parameter int NUM_FU = 2
) (
    input  logic [DEPTH-1:0]              req,
    input  logic [NUM_FU-1:0]             busy,
    output logic [NUM_FU-1:0][DEPTH-1:0]  grant_onehot
);

    ////////////////////////////////////////////////////////////
    // cascaded allocator
    ////////////////////////////////////////////////////////////

    // requests not yet granted to a lower unit
    logic [DEPTH-1:0] remaining;
    logic [DEPTH-1:0] lowest;

    always_comb begin
        remaining = req;
        for (int u = 0; u < NUM_FU; u++) begin
            // two's complement trick keeps only the lowest set bit
            lowest = remaining & (~remaining + DEPTH'(1));

            // busy unit takes nothing, candidate falls through to the next
            grant_onehot[u] = busy[u] ? '0 : lowest;

            if (!busy[u]) begin
                remaining = remaining & ~lowest;
            end
        end
    end

endmodule

//--- source/rs_pkg.sv
package rs_pkg;

    ////////////////////////////////////////////////////////////
    // payload widths
    ////////////////////////////////////////////////////////////

    // physical register tag
    localparam int TAG_WIDTH = 6;

    // instruction word handed to the unit
    localparam int INST_WIDTH = 32;

    // one bit per unresolved branch
    localparam int BR_MASK_WIDTH = 4;

    ////////////////////////////////////////////////////////////
    // encodings
    ////////////////////////////////////////////////////////////

    // functional unit class
    localparam int FU_TYPE_WIDTH = 1;
    localparam logic [FU_TYPE_WIDTH-1:0] FU_ALU = 1'b0;
    localparam logic [FU_TYPE_WIDTH-1:0] FU_MULT = 1'b1;

    // what the branch unit wants done with rem_b_id
    localparam int BR_TASK_WIDTH = 2;
    localparam logic [BR_TASK_WIDTH-1:0] BR_NONE = 2'd0;
    localparam logic [BR_TASK_WIDTH-1:0] BR_SQUASH = 2'd1;
    localparam logic [BR_TASK_WIDTH-1:0] BR_CLEAR = 2'd2;

    // broadcasts per cycle on the common data bus
    localparam int CDB_WIDTH = 2;

endpackage
